/* rv32m_unit.f */
src/word_pkg.sv
src/rv32m_pkg.sv
src/shift_add_multiplier.sv
src/shift_test_restore_divider.sv
src/rv32m_decode.sv
src/rv32m_execute.sv
src/rv32m_result.sv
src/rv32m_unit.sv
bench/rv32m_unit_tb.sv

/* bench/rv32m_unit_tb.sv */
//**************************************************************************
// testbench for the RV32M multiply/divide unit
// credit-tracking random issuer, 64-bit reference model, in-order
// result checks and a cycle-limit watchdog
//**************************************************************************
`timescale 1ns/100ps

module rv32m_unit_tb;
  import word_pkg::*;
  import rv32m_pkg::*;

  localparam int QUEUE_DEPTH = 2;
  localparam int NUM_REQ     = 136;  // 40 + 40 + 8 + 18 + 30
  localparam int CYCLE_LIMIT = NUM_REQ * (WORD_SIZE + 6) + 100;

  logic       CLK, nRST, req_valid;
  logic [2:0] req_funct3;
  word_t      req_rs1, req_rs2;
  logic       credit_return, res_valid;
  word_t      res_data;

  integer seed = 32'h9d0a4c5e;
  int     credits, credit_pending;
  int     cycle_count = 0;
  int     mismatch_count, protocol_count, timeout_count;
  word_t  exp_q[$];   // expected results, request order
  string  name_q[$];

  rv32m_unit #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut0 (
    .CLK(CLK), .nRST(nRST),
    .req_valid(req_valid), .req_funct3(req_funct3),
    .req_rs1(req_rs1), .req_rs2(req_rs2),
    .credit_return(credit_return),
    .res_valid(res_valid), .res_data(res_data)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // ISA results from wide arithmetic
  function automatic word_t model_result(input logic [2:0] f3, input word_t a, input word_t b);
    longint      sa, sb, ub;
    logic [63:0] full;
    sa   = $signed(a);
    sb   = $signed(b);
    ub   = {32'b0, b};
    full = '0;
    model_result = '0;
    case (f3)
      F3_MUL, F3_MULH: full = sa * sb;
      F3_MULHSU:       full = sa * ub;
      F3_MULHU:        full = {32'b0, a} * {32'b0, b};
      default:         full = '0;
    endcase
    case (f3)
      F3_MUL:                       model_result = full[31:0];
      F3_MULH, F3_MULHSU, F3_MULHU: model_result = full[63:32];
      F3_DIV: begin
        if (b == '0)
          model_result = 32'hFFFF_FFFF;
        else if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF)
          model_result = 32'h8000_0000;  // signed overflow
        else
          model_result = word_t'(sa / sb);
      end
      F3_DIVU: model_result = (b == '0) ? 32'hFFFF_FFFF : a / b;
      F3_REM: begin
        if (b == '0)
          model_result = a;
        else if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF)
          model_result = '0;
        else
          model_result = word_t'(sa % sb);  // sign of the dividend
      end
      default: model_result = (b == '0) ? a : a % b;
    endcase
  endfunction

  // full range, or a small value of either sign
  function automatic word_t rand_word();
    word_t w;
    w = $random(seed);
    if (({$random(seed)} % 4) == 0)
      w = word_t'($signed(w) >>> 20);
    return w;
  endfunction

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_credits(input int count, input logic returned);
    if (count > QUEUE_DEPTH) begin
      protocol_count++;
      $display("issuer holds %0d credits, more than the queue depth %0d", count, QUEUE_DEPTH);
    end
    if (returned && count >= QUEUE_DEPTH) begin
      protocol_count++;
      $display("credit returned while no request was outstanding");
    end
  endtask

  // next falling edge, outputs are stable here
  task automatic step_cycle();
    @(negedge CLK);
    credits += credit_pending;  // popped at the last rising edge
    check_credits(credits, credit_return);
    credit_pending = credit_return;
    if (res_valid) begin
      if (exp_q.size() == 0) begin
        protocol_count++;
        $display("result %h arrived with no request outstanding", res_data);
      end else
        check_word(name_q.pop_front(), exp_q.pop_front(), res_data);
    end
  endtask

  task automatic send_req(input string name, input logic [2:0] f3, input word_t a,
                          input word_t b);
    while (credits == 0)
      step_cycle();
    req_valid  = 1'b1;
    req_funct3 = f3;
    req_rs1    = a;
    req_rs2    = b;
    credits--;
    exp_q.push_back(model_result(f3, a, b));
    name_q.push_back(name);
    step_cycle();
    req_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0)
      step_cycle();
  endtask

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d protocol, %0d timeouts",
             mismatch_count, protocol_count, timeout_count);
    if (mismatch_count + protocol_count + timeout_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  endtask

  initial begin : watchdog
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge CLK);
      cycle_count++;
    end
    timeout_count++;
    $display("run did not finish within %0d cycles, %0d results still missing",
             CYCLE_LIMIT, exp_q.size());
    finish_run();
  end

  initial begin : main
    logic [2:0] f3;
    word_t      a, b;
    nRST           = 1'b0;
    req_valid      = 1'b0;
    req_funct3     = '0;
    req_rs1        = '0;
    req_rs2        = '0;
    credits        = QUEUE_DEPTH;
    credit_pending = 0;
    mismatch_count = 0;
    protocol_count = 0;
    timeout_count  = 0;
    repeat (4) @(negedge CLK);
    nRST = 1'b1;

    // quiet after reset
    repeat (6) begin
      step_cycle();
      if (credit_return || res_valid) begin
        protocol_count++;
        $display("credit_return or res_valid active before the first request");
      end
    end

    repeat (40) begin  // mul_random
      f3 = {1'b0, 2'($random(seed))};
      a  = rand_word();
      b  = rand_word();
      send_req("mul_random", f3, a, b);
      repeat ({$random(seed)} % 4) step_cycle();
    end
    drain();

    repeat (40) begin  // div_random
      f3 = {1'b1, 2'($random(seed))};
      a  = rand_word();
      b  = rand_word();
      if (b == '0)
        b = 32'd7;
      send_req("div_random", f3, a, b);
      repeat ({$random(seed)} % 4) step_cycle();
    end
    drain();

    // zero divisor on all four, then most negative by -1
    send_req("div_special", F3_DIV, rand_word(), '0);
    send_req("div_special", F3_DIVU, rand_word(), '0);
    send_req("div_special", F3_REM, rand_word(), '0);
    send_req("div_special", F3_REMU, rand_word(), '0);
    send_req("div_special", F3_DIV, 32'h8000_0000, 32'hFFFF_FFFF);
    send_req("div_special", F3_REM, 32'h8000_0000, 32'hFFFF_FFFF);
    send_req("div_special", F3_DIVU, 32'h8000_0000, 32'hFFFF_FFFF);
    send_req("div_special", F3_REMU, 32'h8000_0000, 32'hFFFF_FFFF);
    drain();

    repeat (6) begin  // repeat_request
      f3 = 3'($random(seed));
      a  = rand_word();
      b  = rand_word();
      if (b == '0)
        b = 32'd3;
      send_req("repeat_request", f3, a, b);
      send_req("repeat_request", f3, a, b);
      send_req("repeat_request", f3 ^ 3'b001, a, b);  // MUL/MULH, DIV/DIVU, ...
    end
    drain();

    repeat (30) begin  // credit_flow, no gaps
      f3 = 3'($random(seed));
      a  = rand_word();
      b  = rand_word();
      send_req("credit_flow", f3, a, b);
    end
    drain();
    repeat (4) step_cycle();  // catch a late duplicate

    finish_run();
  end

endmodule

/* src/rv32m_unit.sv */
//**************************************************************************
// RV32M multiply/divide unit
// decode queue, execute with the arithmetic cores, and result select
//**************************************************************************
`timescale 1ns/100ps

module rv32m_unit #(
  parameter int QUEUE_DEPTH = 2
) (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            req_valid,
  input  logic [2:0]      req_funct3,
  input  word_pkg::word_t req_rs1,
  input  word_pkg::word_t req_rs2,
  output logic            credit_return,
  output logic            res_valid,
  output word_pkg::word_t res_data
);
  import word_pkg::*;

  // decode to execute
  logic                   dec_valid, dec_lower, exe_ready;
  logic [2:0]             dec_op;
  logic [1:0]             dec_sign;
  word_t                  dec_a, dec_b;

  // execute to result
  logic                   exe_done, exe_lower, exe_divz, exe_ovf;
  logic [2:0]             exe_op;
  word_t                  exe_a, exe_quotient, exe_remainder;
  logic [2*WORD_SIZE-1:0] exe_product;

  rv32m_decode #(.QUEUE_DEPTH(QUEUE_DEPTH)) decode0 (
    .CLK(CLK), .nRST(nRST),
    .req_valid(req_valid), .req_funct3(req_funct3),
    .req_rs1(req_rs1), .req_rs2(req_rs2),
    .exe_ready(exe_ready), .credit_return(credit_return),
    .dec_valid(dec_valid), .dec_op(dec_op), .dec_sign(dec_sign),
    .dec_lower(dec_lower), .dec_a(dec_a), .dec_b(dec_b)
  );

  rv32m_execute execute0 (
    .CLK(CLK), .nRST(nRST),
    .dec_valid(dec_valid), .dec_op(dec_op), .dec_sign(dec_sign),
    .dec_lower(dec_lower), .dec_a(dec_a), .dec_b(dec_b),
    .exe_ready(exe_ready), .exe_done(exe_done),
    .exe_op(exe_op), .exe_lower(exe_lower),
    .exe_divz(exe_divz), .exe_ovf(exe_ovf), .exe_a(exe_a),
    .exe_product(exe_product),
    .exe_quotient(exe_quotient), .exe_remainder(exe_remainder)
  );

  rv32m_result result0 (
    .CLK(CLK), .nRST(nRST),
    .exe_done(exe_done), .exe_op(exe_op), .exe_lower(exe_lower),
    .exe_divz(exe_divz), .exe_ovf(exe_ovf), .exe_a(exe_a),
    .exe_product(exe_product),
    .exe_quotient(exe_quotient), .exe_remainder(exe_remainder),
    .res_valid(res_valid), .res_data(res_data)
  );

endmodule

/* src/rv32m_result.sv */
//**************************************************************************
// RV32M result stage
// picks product half or quotient/remainder, applies the ISA values for
// division by zero and signed overflow, registers the write value
//**************************************************************************
`timescale 1ns/100ps

module rv32m_result (
  input  logic                             CLK,
  input  logic                             nRST,
  input  logic                             exe_done,
  input  logic [2:0]                       exe_op,
  input  logic                             exe_lower,
  input  logic                             exe_divz,
  input  logic                             exe_ovf,
  input  word_pkg::word_t                  exe_a,
  input  logic [2*word_pkg::WORD_SIZE-1:0] exe_product,
  input  word_pkg::word_t                  exe_quotient,
  input  word_pkg::word_t                  exe_remainder,
  output logic                             res_valid,
  output word_pkg::word_t                  res_data
);
  import word_pkg::*;
  import rv32m_pkg::*;

  word_t sel_data;

  always_comb begin
    case (exe_op)
      OP_MUL:
        sel_data = exe_lower ? exe_product[WORD_SIZE-1:0]
                             : exe_product[2*WORD_SIZE-1:WORD_SIZE];
      OP_DIV:
        sel_data = exe_divz ? DIVZ_UNSIGNED_Q :
                   exe_ovf  ? OVF_QUOTIENT    : exe_quotient;
      OP_REM:
        sel_data = exe_divz ? exe_a         :  // x % 0 gives x
                   exe_ovf  ? OVF_REMAINDER : exe_remainder;
      default:
        sel_data = '0;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      res_valid <= 1'b0;
    else
      res_valid <= exe_done;
  end

  always_ff @(posedge CLK) begin
    if (exe_done)
      res_data <= sel_data;
  end

endmodule

/* src/rv32m_execute.sv */
//**************************************************************************
// RV32M execute stage
// operand saver for repeated requests, special case detection for
// division, and start of the multiplier and divider cores
//**************************************************************************
`timescale 1ns/100ps

module rv32m_execute (
  input  logic                             CLK,
  input  logic                             nRST,
  input  logic                             dec_valid,
  input  logic [2:0]                       dec_op,
  input  logic [1:0]                       dec_sign,
  input  logic                             dec_lower,
  input  word_pkg::word_t                  dec_a,
  input  word_pkg::word_t                  dec_b,
  output logic                             exe_ready,
  output logic                             exe_done,
  output logic [2:0]                       exe_op,
  output logic                             exe_lower,
  output logic                             exe_divz,
  output logic                             exe_ovf,
  output word_pkg::word_t                  exe_a,
  output logic [2*word_pkg::WORD_SIZE-1:0] exe_product,
  output word_pkg::word_t                  exe_quotient,
  output word_pkg::word_t                  exe_remainder
);
  import word_pkg::*;
  import rv32m_pkg::*;

  word_t      sv_a, sv_b;
  logic [2:0] sv_op;
  logic [1:0] sv_sign;
  logic       pop, repeat_req, is_div, divz, ovf;
  logic       mul_start, div_start, mul_finished, div_finished;
  logic       busy, quick_done;

  assign pop       = dec_valid & exe_ready;
  assign exe_ready = ~busy;

  // same op and operands as the last started request
  assign repeat_req = (dec_op == sv_op) && (dec_sign == sv_sign) &&
                      (dec_a == sv_a) && (dec_b == sv_b);

  assign is_div = (dec_op == OP_DIV) || (dec_op == OP_REM);
  assign divz   = is_div && (dec_b == '0);
  assign ovf    = is_div && (dec_sign == SGN_SS) &&
                  (dec_a == MIN_SIGNED) && (dec_b == '1);

  assign mul_start = pop && !repeat_req && (dec_op == OP_MUL);
  assign div_start = pop && !repeat_req && is_div && !divz && !ovf;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy       <= 1'b0;
      quick_done <= 1'b0;
      sv_op      <= '0;  // matches no one-hot op
      sv_sign    <= '0;
    end else begin
      quick_done <= pop && !mul_start && !div_start;  // answered without a core
      if (mul_start || div_start)
        busy <= 1'b1;
      else if (mul_finished || div_finished)
        busy <= 1'b0;
      if (pop && !repeat_req) begin
        sv_op   <= dec_op;
        sv_sign <= dec_sign;
      end
    end
  end

  // saved operands and per-request info for the result stage
  always_ff @(posedge CLK) begin
    if (pop && !repeat_req) begin
      sv_a <= dec_a;
      sv_b <= dec_b;
    end
    if (pop) begin
      exe_op    <= dec_op;
      exe_lower <= dec_lower;
      exe_divz  <= divz;
      exe_ovf   <= ovf;
      exe_a     <= dec_a;
    end
  end

  assign exe_done = quick_done | mul_finished | div_finished;

  shift_add_multiplier #(.N(WORD_SIZE)) mult0 (
    .CLK          (CLK),
    .nRST         (nRST),
    .multiplicand (dec_a),
    .multiplier   (dec_b),
    .is_signed    (dec_sign),
    .start        (mul_start),
    .product      (exe_product),
    .finished     (mul_finished)
  );

  shift_test_restore_divider #(.N(WORD_SIZE)) div0 (
    .CLK       (CLK),
    .nRST      (nRST),
    .dividend  (dec_a),
    .divisor   (dec_b),
    .is_signed (dec_sign == SGN_SS),
    .start     (div_start),
    .quotient  (exe_quotient),
    .remainder (exe_remainder),
    .finished  (div_finished)
  );

  // one core at a time, so completions never overlap
  a_one_done_source: assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0({quick_done, mul_finished, div_finished}))
    else $error("more than one completion source active in one cycle");

endmodule

/* src/rv32m_decode.sv */
//**************************************************************************
// RV32M decode stage
// queues requests under credit flow control and splits the head
// entry's funct3 into operation, signedness and product half
//**************************************************************************
`timescale 1ns/100ps

module rv32m_decode #(
  parameter int QUEUE_DEPTH = 2
) (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            req_valid,
  input  logic [2:0]      req_funct3,
  input  word_pkg::word_t req_rs1,
  input  word_pkg::word_t req_rs2,
  input  logic            exe_ready,
  output logic            credit_return,
  output logic            dec_valid,
  output logic [2:0]      dec_op,
  output logic [1:0]      dec_sign,
  output logic            dec_lower,
  output word_pkg::word_t dec_a,
  output word_pkg::word_t dec_b
);
  import word_pkg::*;
  import rv32m_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  logic [2:0]       q_funct3 [QUEUE_DEPTH];
  word_t            q_rs1 [QUEUE_DEPTH];
  word_t            q_rs2 [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push, pop, full;
  logic [2:0]       head_f3;

  assign push          = req_valid;
  assign pop           = dec_valid & exe_ready;
  assign full          = (count == CNT_W'(QUEUE_DEPTH));
  assign dec_valid     = (count != '0);
  assign credit_return = pop;  // slot freed, credit goes back

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (push) begin
      q_funct3[wr_ptr] <= req_funct3;
      q_rs1[wr_ptr]    <= req_rs1;
      q_rs2[wr_ptr]    <= req_rs2;
    end
  end

  assign head_f3 = q_funct3[rd_ptr];
  assign dec_a   = q_rs1[rd_ptr];
  assign dec_b   = q_rs2[rd_ptr];

  always_comb begin
    dec_op    = OP_MUL;
    dec_sign  = SGN_SS;
    dec_lower = 1'b0;
    case (head_f3)
      F3_MUL:    dec_lower = 1'b1;  // low word, sign does not matter
      F3_MULH:   dec_sign  = SGN_SS;
      F3_MULHSU: dec_sign  = SGN_SU;
      F3_MULHU:  dec_sign  = SGN_UU;
      F3_DIV:    dec_op    = OP_DIV;
      F3_DIVU: begin
        dec_op   = OP_DIV;
        dec_sign = SGN_UU;
      end
      F3_REM:    dec_op    = OP_REM;
      F3_REMU: begin
        dec_op   = OP_REM;
        dec_sign = SGN_UU;
      end
      default:   dec_op    = OP_MUL;
    endcase
  end

  // issuer must hold a credit, so a full queue never sees a push
  a_no_push_when_full: assert property (@(posedge CLK) disable iff (!nRST)
    req_valid |-> !full)
    else $error("request pushed into a full queue, credit rule broken");

endmodule

/* src/shift_test_restore_divider.sv */
//**************************************************************************
// iterative restoring divider
// N shift/test/restore steps on magnitudes, then one sign fix-up cycle;
// quotient and remainder held until the next start
//**************************************************************************
`timescale 1ns/100ps

module shift_test_restore_divider #(
  parameter int N = 32
) (
  input  logic         CLK,
  input  logic         nRST,
  input  logic [N-1:0] dividend,
  input  logic [N-1:0] divisor,
  input  logic         is_signed,
  input  logic         start,
  output logic [N-1:0] quotient,
  output logic [N-1:0] remainder,
  output logic         finished
);

  localparam int CW = (N > 1) ? $clog2(N) : 1;

  logic [N-1:0]  quo, rem, dmag, a_mag, b_mag;
  logic [N:0]    shifted, diff;
  logic          a_neg, b_neg, q_neg, r_neg;
  logic          busy, fixup, take_sub;
  logic [CW-1:0] step;

  assign a_neg = is_signed & dividend[N-1];
  assign b_neg = is_signed & divisor[N-1];
  assign a_mag = a_neg ? (~dividend + 1'b1) : dividend;
  assign b_mag = b_neg ? (~divisor + 1'b1) : divisor;

  // bring in the next dividend bit and trial subtract
  assign shifted  = {rem, quo[N-1]};
  assign diff     = shifted - {1'b0, dmag};
  assign take_sub = ~diff[N];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy     <= 1'b0;
      fixup    <= 1'b0;
      finished <= 1'b0;
      step     <= '0;
    end else begin
      finished <= fixup;
      fixup    <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        step <= step + 1'b1;
        if (step == CW'(N-1)) begin
          busy  <= 1'b0;
          fixup <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      quo   <= a_mag;
      rem   <= '0;
      dmag  <= b_mag;
      q_neg <= a_neg ^ b_neg;
      r_neg <= a_neg;  // remainder follows the dividend
    end else if (busy) begin
      rem <= take_sub ? diff[N-1:0] : shifted[N-1:0];
      quo <= {quo[N-2:0], take_sub};
    end
    if (fixup) begin
      quotient  <= q_neg ? (~quo + 1'b1) : quo;
      remainder <= r_neg ? (~rem + 1'b1) : rem;
    end
  end

  // zero divisors are answered upstream
  a_no_zero_divisor: assert property (@(posedge CLK) disable iff (!nRST)
    start |-> (divisor != '0))
    else $error("divider started with a zero divisor");

endmodule

/* src/shift_add_multiplier.sv */
//**************************************************************************
// iterative shift-add multiplier
// unsigned, signed or mixed operands, one partial product per cycle,
// full 2N-bit product held until the next start
//**************************************************************************
`timescale 1ns/100ps

module shift_add_multiplier #(
  parameter int N = 32
) (
  input  logic           CLK,
  input  logic           nRST,
  input  logic [N-1:0]   multiplicand,
  input  logic [N-1:0]   multiplier,
  input  logic [1:0]     is_signed,
  input  logic           start,
  output logic [2*N-1:0] product,
  output logic           finished
);

  localparam int CW = (N > 1) ? $clog2(N) : 1;

  logic [2*N-1:0] acc, mcand_sh;
  logic [N-1:0]   mplier_sh, a_mag, b_mag;
  logic           a_neg, b_neg, negate_q, busy;
  logic [CW-1:0]  step;

  assign a_neg = is_signed[1] & multiplicand[N-1];
  assign b_neg = is_signed[0] & multiplier[N-1];
  assign a_mag = a_neg ? (~multiplicand + 1'b1) : multiplicand;
  assign b_mag = b_neg ? (~multiplier + 1'b1) : multiplier;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy     <= 1'b0;
      finished <= 1'b0;
      step     <= '0;
    end else begin
      finished <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        step <= step + 1'b1;
        if (step == CW'(N-1)) begin  // last partial product
          busy     <= 1'b0;
          finished <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      acc       <= '0;
      mcand_sh  <= {{N{1'b0}}, a_mag};
      mplier_sh <= b_mag;
      negate_q  <= a_neg ^ b_neg;
    end else if (busy) begin
      if (mplier_sh[0])
        acc <= acc + mcand_sh;
      mcand_sh  <= mcand_sh << 1;
      mplier_sh <= mplier_sh >> 1;
    end
  end

  // sign applied on the way out
  assign product = negate_q ? (~acc + 1'b1) : acc;

endmodule

/* src/rv32m_pkg.sv */
//**************************************************************************
// RV32M instruction encodings
// funct3 values, multiplier signedness codes and one-hot operations
//**************************************************************************

package rv32m_pkg;

  // funct3 of the M extension
  parameter logic [2:0] F3_MUL    = 3'b000;
  parameter logic [2:0] F3_MULH   = 3'b001;
  parameter logic [2:0] F3_MULHSU = 3'b010;
  parameter logic [2:0] F3_MULHU  = 3'b011;
  parameter logic [2:0] F3_DIV    = 3'b100;
  parameter logic [2:0] F3_DIVU   = 3'b101;
  parameter logic [2:0] F3_REM    = 3'b110;
  parameter logic [2:0] F3_REMU   = 3'b111;

  // bit 1 for operand a, bit 0 for operand b
  parameter logic [1:0] SGN_UU = 2'b00;
  parameter logic [1:0] SGN_SU = 2'b10;
  parameter logic [1:0] SGN_SS = 2'b11;

  // one-hot, mul / div / rem
  parameter logic [2:0] OP_MUL = 3'b100;
  parameter logic [2:0] OP_DIV = 3'b010;
  parameter logic [2:0] OP_REM = 3'b001;

endpackage

/* src/word_pkg.sv */
//**************************************************************************
// word definitions for the RV32M unit
// datapath width, word type and the ISA results for the special
// division cases
//**************************************************************************

package word_pkg;

  parameter int WORD_SIZE = 32;

  typedef logic [WORD_SIZE-1:0] word_t;

  // division by zero, quotient is all ones either way
  parameter word_t DIVZ_SIGNED_Q   = '1;
  parameter word_t DIVZ_UNSIGNED_Q = DIVZ_SIGNED_Q;  // same value per ISA

  // most negative / -1
  parameter word_t OVF_QUOTIENT    = 32'h8000_0000;
  parameter word_t OVF_REMAINDER   = '0;
  parameter word_t MIN_SIGNED      = 32'h8000_0000;

endpackage
